//--- src/vga_lcd_defs.svh
// VGA scan-out engine parameters
// Bus widths, burst length and pixel FIFO sizing
`ifndef VGA_LCD_DEFS_SVH
`define VGA_LCD_DEFS_SVH

// Byte address width of the frame memory
`define VGA_ADR_W 20

// Words fetched per burst
`define VGA_BURST_LEN 8

// Pixel FIFO holds 2**5 tokens
`define VGA_FIFO_AW 5

// Highest FIFO level at which a burst may start
`define VGA_FIFO_ROOM 20

`endif

//--- src/vga_lcd_pkg.sv
// VGA scan-out engine types
// Timing configuration, beam flags, FIFO pixel token and pad color
package vga_lcd_pkg;

  // Raster geometry, horizontal in pixels and vertical in lines
  typedef struct packed {
    logic [9:0] h_total;
    logic [9:0] h_visible;
    logic [9:0] h_sync_start;
    logic [9:0] h_sync_end;
    logic [9:0] v_total;
    logic [9:0] v_visible;
    logic [9:0] v_sync_start;
    logic [9:0] v_sync_end;
  } crtc_cfg_t;

  // Beam state for one pixel, syncs active low
  typedef struct packed {
    logic hsync;
    logic vsync;
    logic h_on;
    logic v_on;
  } beam_t;

  // FIFO word
  typedef struct packed {
    beam_t      beam;
    logic [3:0] idx;
  } pix_tok_t;

  typedef struct packed {
    logic [3:0] red;
    logic [3:0] green;
    logic [3:0] blue;
  } rgb_t;

endpackage

//--- src/vga_crtc.sv
// CRT timing generator
// Horizontal and vertical beam counters advanced by the step pulse,
// with sync and display-enable decode
`timescale 1ns/1ps

module vga_crtc import vga_lcd_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       step_i,
  input  crtc_cfg_t  cfg_i,
  output beam_t      beam_o,
  output logic [9:0] h_cnt_o,
  output logic [9:0] v_cnt_o
);

  logic h_last;
  logic v_last;

  // Last pixel of line, last line of frame
  assign h_last = (h_cnt_o == cfg_i.h_total - 10'd1);
  assign v_last = (v_cnt_o == cfg_i.v_total - 10'd1);

  always_ff @(posedge clk) begin
    if (rst) begin
      // Beam starts at top of vertical sync so the first frame gets prefetched
      h_cnt_o <= '0;
      v_cnt_o <= cfg_i.v_sync_start;
    end else if (step_i) begin
      if (h_last) begin
        h_cnt_o <= '0;
        if (v_last) begin
          v_cnt_o <= '0;
        end else begin
          v_cnt_o <= v_cnt_o + 10'd1;
        end
      end else begin
        h_cnt_o <= h_cnt_o + 10'd1;
      end
    end
  end

  // Syncs low inside [start, end)
  assign beam_o.hsync = !((h_cnt_o >= cfg_i.h_sync_start) && (h_cnt_o < cfg_i.h_sync_end));
  assign beam_o.vsync = !((v_cnt_o >= cfg_i.v_sync_start) && (v_cnt_o < cfg_i.v_sync_end));

  // Display enables
  assign beam_o.h_on = (h_cnt_o < cfg_i.h_visible);
  assign beam_o.v_on = (v_cnt_o < cfg_i.v_visible);

endmodule

//--- src/vga_sequencer.sv
// Pixel sequencer
// Double-buffered burst banks filled by the fetch controller and
// unpacked four pixels per word, low nibble first, into FIFO tokens
`timescale 1ns/1ps
`include "vga_lcd_defs.svh"

module vga_sequencer import vga_lcd_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        step_i,
  input  beam_t       beam_i,
  input  logic [9:0]  h_cnt_i,
  input  logic [9:0]  v_cnt_i,
  input  crtc_cfg_t   cfg_i,
  input  logic        word_vld_i,
  input  logic [15:0] word_dat_i,
  output logic        burst_req_o,
  output logic [16:0] burst_wadr_o,
  output pix_tok_t    tok_o
);

  localparam int BL = `VGA_BURST_LEN;
  localparam int WB = $clog2(BL);

  logic [15:0]   bank_mem [2*BL];
  logic [1:0]    bank_full;
  logic          load_bank;
  logic [WB-1:0] load_idx;
  logic          disp_bank;
  logic [16:0]   fetch_ptr;
  logic [17:0]   frame_words;
  logic          frame_clr;
  logic          vis_step;
  logic          bank_end;
  logic [15:0]   disp_word;
  logic [3:0]    nibble;

  // Words in one frame, four pixels per word
  assign frame_words = cfg_i.h_visible[9:2] * cfg_i.v_visible;

  // First step of vertical sync restarts the frame fetch
  assign frame_clr = step_i && (h_cnt_i == 10'd0) && (v_cnt_i == cfg_i.v_sync_start);

  assign vis_step = step_i && beam_i.h_on && beam_i.v_on;

  // Lines are a whole number of banks, so h_cnt indexes the bank directly
  assign bank_end  = &h_cnt_i[WB+1:0];
  assign disp_word = bank_mem[{disp_bank, h_cnt_i[WB+1:2]}];
  assign nibble    = disp_word[{h_cnt_i[1:0], 2'b00} +: 4];

  // Ask for a burst while the loading bank is free and words remain
  assign burst_req_o  = !bank_full[load_bank] && ({1'b0, fetch_ptr} < frame_words);
  assign burst_wadr_o = fetch_ptr;

  assign tok_o.beam = beam_i;
  assign tok_o.idx  = (beam_i.h_on && beam_i.v_on) ? nibble : 4'd0;

  always_ff @(posedge clk) begin
    if (word_vld_i) begin
      bank_mem[{load_bank, load_idx}] <= word_dat_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst || frame_clr) begin
      bank_full <= '0;
      load_bank <= 1'b0;
      load_idx  <= '0;
      disp_bank <= 1'b0;
      fetch_ptr <= '0;
    end else begin
      if (word_vld_i) begin
        load_idx <= load_idx + 1'b1;
        // Last beat completes the bank
        if (&load_idx) begin
          bank_full[load_bank] <= 1'b1;
          load_bank            <= !load_bank;
          fetch_ptr            <= fetch_ptr + 17'(BL);
        end
      end
      // Last pixel of displayed bank frees it
      if (vis_step && bank_end) begin
        bank_full[disp_bank] <= 1'b0;
        disp_bank            <= !disp_bank;
      end
    end
  end

endmodule

//--- src/vga_fifo.sv
// Synchronous FIFO, first-word-fall-through
// Circular buffer with fill level, empty and full flags
`timescale 1ns/1ps

module vga_fifo #(
  parameter int AW = 5,
  parameter int DW = 8
) (
  input  logic          clk,
  input  logic          rst,
  input  logic          wr_i,
  input  logic [DW-1:0] wdat_i,
  input  logic          rd_i,
  output logic [DW-1:0] rdat_o,
  output logic [AW:0]   level_o,
  output logic          empty_o,
  output logic          full_o
);

  logic [DW-1:0] mem [2**AW];
  logic [AW:0]   wptr;
  logic [AW:0]   rptr;
  logic          do_wr;
  logic          do_rd;

  // Overflow and underflow requests dropped
  assign do_wr = wr_i && !full_o;
  assign do_rd = rd_i && !empty_o;

  // Extra pointer bit tells full from empty
  assign level_o = wptr - rptr;
  assign empty_o = (wptr == rptr);
  assign full_o  = (wptr[AW] != rptr[AW]) && (wptr[AW-1:0] == rptr[AW-1:0]);

  // Head word always on the output
  assign rdat_o = mem[rptr[AW-1:0]];

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wptr[AW-1:0]] <= wdat_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wptr <= '0;
      rptr <= '0;
    end else begin
      if (do_wr) begin
        wptr <= wptr + 1'b1;
      end
      if (do_rd) begin
        rptr <= rptr + 1'b1;
      end
    end
  end

endmodule

//--- src/vga_fetch_ctrl.sv
// Fetch controller
// Paces the raster and runs 8-word bursts, cache bus first and
// FML on a miss, forming the byte address of every burst
`timescale 1ns/1ps
`include "vga_lcd_defs.svh"

module vga_fetch_ctrl (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  burst_req_i,
  input  logic [16:0]           burst_wadr_i,
  input  logic [15:0]           start_addr_i,
  input  logic [`VGA_FIFO_AW:0] fifo_level_i,
  input  logic                  fifo_full_i,
  output logic [`VGA_ADR_W-1:0] fml_adr_o,
  output logic                  fml_stb_o,
  input  logic                  fml_ack_i,
  input  logic [15:0]           fml_dat_i,
  output logic                  dcb_stb_o,
  output logic [`VGA_ADR_W-1:0] dcb_adr_o,
  input  logic [15:0]           dcb_dat_i,
  input  logic                  dcb_hit_i,
  output logic                  step_o,
  output logic                  word_vld_o,
  output logic [15:0]           word_dat_o
);

  localparam int AW = `VGA_ADR_W;
  localparam int BW = $clog2(`VGA_BURST_LEN);

  typedef enum logic [4:0] {
    IDLE, DELAY, TRYCACHE,
    CACHE1, CACHE2, CACHE3, CACHE4, CACHE5, CACHE6, CACHE7, CACHE8,
    FML1, FML2, FML3, FML4, FML5, FML6, FML7, FML8
  } state_t;

  state_t        state;
  state_t        state_nxt;
  logic          room;
  logic          start_burst;
  logic          from_cache;
  logic [BW-1:0] dcb_idx;
  logic [AW-2:0] word_adr;

  // Enough FIFO space for all tokens of one burst
  assign room        = (fifo_level_i <= `VGA_FIFO_ROOM) && !fifo_full_i;
  assign start_burst = (state == IDLE) && room && burst_req_i;

  // Word address of the burst, frame base plus offset
  assign word_adr = {{(AW-17){1'b0}}, start_addr_i} + {{(AW-18){1'b0}}, burst_wadr_i};

  // Beat data source
  assign from_cache = state inside {[CACHE1:CACHE8]};
  assign word_dat_o = from_cache ? dcb_dat_i : fml_dat_i;

  // Byte address of the word being asked of the cache
  assign dcb_adr_o = fml_adr_o + {{(AW-BW-1){1'b0}}, dcb_idx, 1'b0};

  always_comb begin
    state_nxt  = state;
    step_o     = 1'b0;
    word_vld_o = 1'b0;
    fml_stb_o  = 1'b0;
    dcb_stb_o  = 1'b0;
    case (state)
      IDLE: begin
        if (start_burst) begin
          state_nxt = DELAY;
        end else if (room) begin
          step_o = 1'b1;
        end
      end
      DELAY: begin
        step_o    = 1'b1;
        state_nxt = TRYCACHE;
      end
      TRYCACHE: begin
        step_o    = 1'b1;
        dcb_stb_o = 1'b1;
        state_nxt = CACHE1;
      end
      // Hit on the first word locks the line for the rest
      CACHE1: begin
        if (dcb_hit_i) begin
          step_o     = 1'b1;
          word_vld_o = 1'b1;
          dcb_stb_o  = 1'b1;
          state_nxt  = CACHE2;
        end else begin
          state_nxt = FML1;
        end
      end
      CACHE2, CACHE3, CACHE4, CACHE5, CACHE6, CACHE7: begin
        step_o     = 1'b1;
        word_vld_o = 1'b1;
        dcb_stb_o  = 1'b1;
        state_nxt  = state_t'(state + 5'd1);
      end
      // Hold the request until memory acks, beat 0 comes with the ack
      FML1: begin
        fml_stb_o = 1'b1;
        if (fml_ack_i) begin
          step_o     = 1'b1;
          word_vld_o = 1'b1;
          state_nxt  = FML2;
        end
      end
      FML2, FML3, FML4, FML5, FML6, FML7: begin
        step_o     = 1'b1;
        word_vld_o = 1'b1;
        state_nxt  = state_t'(state + 5'd1);
      end
      CACHE8, FML8: begin
        step_o     = 1'b1;
        word_vld_o = 1'b1;
        state_nxt  = IDLE;
      end
      default: begin
        state_nxt = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= IDLE;
      fml_adr_o <= '0;
    end else begin
      state <= state_nxt;
      if (start_burst) begin
        fml_adr_o <= {word_adr, 1'b0};
      end
    end
  end

  // Beat index restarts whenever the cache strobe drops
  always_ff @(posedge clk) begin
    if (rst || !dcb_stb_o) begin
      dcb_idx <= '0;
    end else begin
      dcb_idx <= dcb_idx + 1'b1;
    end
  end

endmodule

//--- src/vga_pal_out.sv
// Palette and pad output stage
// Pops one token every fourth clock, looks up the 16-entry palette
// and registers color and syncs onto the pads
`timescale 1ns/1ps

module vga_pal_out import vga_lcd_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  pix_tok_t   tok_i,
  input  logic       fifo_empty_i,
  input  logic       pal_we_i,
  input  logic [3:0] pal_addr_i,
  input  rgb_t       pal_dat_i,
  output logic       rd_o,
  output logic       pix_stb_o,
  output rgb_t       rgb_o,
  output logic       hsync_o,
  output logic       vsync_o
);

  logic [1:0] div;
  rgb_t       pal_mem [16];

  // Pixel tick once per four clocks, skipped when nothing is queued
  assign rd_o      = (div == 2'd0) && !fifo_empty_i;
  assign pix_stb_o = rd_o;

  always_ff @(posedge clk) begin
    if (rst) begin
      div <= '0;
    end else begin
      div <= div + 2'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (pal_we_i) begin
      pal_mem[pal_addr_i] <= pal_dat_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rgb_o   <= '0;
      hsync_o <= 1'b1;
      vsync_o <= 1'b1;
    end else if (rd_o) begin
      hsync_o <= tok_i.beam.hsync;
      vsync_o <= tok_i.beam.vsync;
      // Black outside the visible area
      rgb_o   <= (tok_i.beam.h_on && tok_i.beam.v_on) ? pal_mem[tok_i.idx] : '0;
    end
  end

endmodule

//--- src/vga_lcd_top.sv
// VGA scan-out engine
// Fetch controller, timing generator, sequencer, pixel FIFO and
// palette stage joined into one 4-bit-per-pixel display pipeline
`timescale 1ns/1ps
`include "vga_lcd_defs.svh"

module vga_lcd_top import vga_lcd_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  crtc_cfg_t             cfg_i,
  input  logic [15:0]           start_addr_i,
  output logic [`VGA_ADR_W-1:0] fml_adr_o,
  output logic                  fml_stb_o,
  input  logic                  fml_ack_i,
  input  logic [15:0]           fml_dat_i,
  output logic                  dcb_stb_o,
  output logic [`VGA_ADR_W-1:0] dcb_adr_o,
  input  logic [15:0]           dcb_dat_i,
  input  logic                  dcb_hit_i,
  input  logic                  pal_we_i,
  input  logic [3:0]            pal_addr_i,
  input  rgb_t                  pal_dat_i,
  output rgb_t                  rgb_o,
  output logic                  hsync_o,
  output logic                  vsync_o,
  output logic                  pix_stb_o
);

  logic                  step;
  beam_t                 beam;
  logic [9:0]            h_cnt;
  logic [9:0]            v_cnt;
  logic                  burst_req;
  logic [16:0]           burst_wadr;
  logic                  word_vld;
  logic [15:0]           word_dat;
  pix_tok_t              tok_in;
  pix_tok_t              tok_out;
  logic                  fifo_rd;
  logic [`VGA_FIFO_AW:0] fifo_level;
  logic                  fifo_empty;
  logic                  fifo_full;

  vga_crtc u_crtc (
    .clk     (clk),
    .rst     (rst),
    .step_i  (step),
    .cfg_i   (cfg_i),
    .beam_o  (beam),
    .h_cnt_o (h_cnt),
    .v_cnt_o (v_cnt)
  );

  vga_sequencer u_seq (
    .clk          (clk),
    .rst          (rst),
    .step_i       (step),
    .beam_i       (beam),
    .h_cnt_i      (h_cnt),
    .v_cnt_i      (v_cnt),
    .cfg_i        (cfg_i),
    .word_vld_i   (word_vld),
    .word_dat_i   (word_dat),
    .burst_req_o  (burst_req),
    .burst_wadr_o (burst_wadr),
    .tok_o        (tok_in)
  );

  // Each step pushes one token
  vga_fifo #(
    .AW (`VGA_FIFO_AW),
    .DW ($bits(pix_tok_t))
  ) u_fifo (
    .clk     (clk),
    .rst     (rst),
    .wr_i    (step),
    .wdat_i  (tok_in),
    .rd_i    (fifo_rd),
    .rdat_o  (tok_out),
    .level_o (fifo_level),
    .empty_o (fifo_empty),
    .full_o  (fifo_full)
  );

  vga_fetch_ctrl u_fetch (
    .clk          (clk),
    .rst          (rst),
    .burst_req_i  (burst_req),
    .burst_wadr_i (burst_wadr),
    .start_addr_i (start_addr_i),
    .fifo_level_i (fifo_level),
    .fifo_full_i  (fifo_full),
    .fml_adr_o    (fml_adr_o),
    .fml_stb_o    (fml_stb_o),
    .fml_ack_i    (fml_ack_i),
    .fml_dat_i    (fml_dat_i),
    .dcb_stb_o    (dcb_stb_o),
    .dcb_adr_o    (dcb_adr_o),
    .dcb_dat_i    (dcb_dat_i),
    .dcb_hit_i    (dcb_hit_i),
    .step_o       (step),
    .word_vld_o   (word_vld),
    .word_dat_o   (word_dat)
  );

  vga_pal_out u_pal (
    .clk          (clk),
    .rst          (rst),
    .tok_i        (tok_out),
    .fifo_empty_i (fifo_empty),
    .pal_we_i     (pal_we_i),
    .pal_addr_i   (pal_addr_i),
    .pal_dat_i    (pal_dat_i),
    .rd_o         (fifo_rd),
    .pix_stb_o    (pix_stb_o),
    .rgb_o        (rgb_o),
    .hsync_o      (hsync_o),
    .vsync_o      (vsync_o)
  );

endmodule

//--- sim/vga_lcd_mem.sv
// Frame memory model for the VGA scan-out testbench
// FML read slave with random ack latency and a direct cache
// responder with one random hit decision per burst
`timescale 1ns/1ps
`include "vga_lcd_defs.svh"

module vga_lcd_mem #(
  parameter int          WORDS = 4096,
  parameter logic [31:0] SEED  = 32'hd3195dca
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [7:0]            hit_pct_i,
  input  logic [`VGA_ADR_W-1:0] fml_adr_i,
  input  logic                  fml_stb_i,
  output logic                  fml_ack_o,
  output logic [15:0]           fml_dat_o,
  input  logic                  dcb_stb_i,
  input  logic [`VGA_ADR_W-1:0] dcb_adr_i,
  output logic [15:0]           dcb_dat_o,
  output logic                  dcb_hit_o
);

  localparam int WA = $clog2(WORDS);

  logic [15:0]   mem [WORDS];
  integer        seed;
  integer        fml_seed;
  integer        dcb_seed;
  logic          waiting;
  logic          streaming;
  logic [1:0]    wait_cnt;
  logic [2:0]    beat;
  logic          stb_d;
  logic          line_hit;
  logic [WA-1:0] fml_base;

  // Word index of the burst start
  assign fml_base = fml_adr_i[WA:1];

  initial begin
    seed      = SEED;
    fml_ack_o = 1'b0;
    fml_dat_o = '0;
    dcb_dat_o = '0;
    dcb_hit_o = 1'b0;
    for (int k = 0; k < WORDS; k++) begin
      mem[k] = 16'($random(seed));
    end
    // Separate streams so the two ports do not share draw order
    fml_seed = $random(seed);
    dcb_seed = $random(seed);
  end

  // FML slave acks after a random wait and streams the other seven beats back to back
  always @(posedge clk) begin
    if (rst) begin
      fml_ack_o <= #1 1'b0;
      waiting   <= 1'b0;
      streaming <= 1'b0;
      wait_cnt  <= '0;
      beat      <= '0;
    end else begin
      fml_ack_o <= #1 1'b0;
      if (streaming) begin
        fml_dat_o <= #1 mem[fml_base + WA'(beat)];
        beat      <= beat + 3'd1;
        if (beat == 3'd7) begin
          streaming <= 1'b0;
        end
      end else if (waiting) begin
        if (wait_cnt == 2'd0) begin
          fml_ack_o <= #1 1'b1;
          fml_dat_o <= #1 mem[fml_base];
          beat      <= 3'd1;
          streaming <= 1'b1;
          waiting   <= 1'b0;
        end else begin
          wait_cnt <= wait_cnt - 2'd1;
        end
      end else if (fml_stb_i) begin
        waiting  <= 1'b1;
        wait_cnt <= 2'($random(fml_seed));
      end
    end
  end

  // Cache answers one cycle after the strobe
  always @(posedge clk) begin : cache_resp
    logic hit_now;
    if (rst) begin
      dcb_hit_o <= #1 1'b0;
      stb_d     <= 1'b0;
      line_hit  <= 1'b0;
    end else begin
      stb_d     <= dcb_stb_i;
      dcb_dat_o <= #1 mem[dcb_adr_i[WA:1]];
      // Hit or miss decided on the first word of each burst
      if (dcb_stb_i && !stb_d) begin
        hit_now   = ($unsigned($random(dcb_seed)) % 100) < hit_pct_i;
        line_hit  <= hit_now;
        dcb_hit_o <= #1 hit_now;
      end else begin
        dcb_hit_o <= #1 dcb_stb_i && line_hit;
      end
    end
  end

endmodule

//--- sim/vga_lcd_tb.sv
// Testbench for the VGA scan-out engine
// Runs two frames per test and checks pads against a raster model
// built from the timing, the frame memory and the palette
`timescale 1ns/1ps
`include "vga_lcd_defs.svh"

module vga_lcd_tb import vga_lcd_pkg::*; ();

  localparam int CLK_PERIOD  = 8;
  localparam int ADR_W       = `VGA_ADR_W;
  localparam int BURST       = `VGA_BURST_LEN;
  localparam int H_TOT       = 80;
  localparam int H_VIS       = 64;
  localparam int H_SS        = 68;
  localparam int H_SE        = 76;
  localparam int V_TOT       = 8;
  localparam int V_VIS       = 4;
  localparam int V_SS        = 5;
  localparam int V_SE        = 6;
  localparam int FRAME_PIX   = H_TOT * V_TOT;
  localparam int CAP_N       = 2 * FRAME_PIX;
  localparam int BURSTS      = (H_VIS / 4) * V_VIS / BURST;
  localparam int MEM_WORDS   = 4096;
  localparam int NUM_TESTS   = 6;
  localparam int WATCHDOG_NS = NUM_TESTS * CAP_N * 4 * 3 * CLK_PERIOD;

  logic             clk;
  logic             rst;
  crtc_cfg_t        cfg;
  logic [15:0]      start_addr;
  logic [ADR_W-1:0] fml_adr;
  logic             fml_stb;
  logic             fml_ack;
  logic [15:0]      fml_dat;
  logic             dcb_stb;
  logic [ADR_W-1:0] dcb_adr;
  logic [15:0]      dcb_dat;
  logic             dcb_hit;
  logic             pal_we;
  logic [3:0]       pal_addr;
  rgb_t             pal_dat;
  rgb_t             rgb;
  logic             hsync;
  logic             vsync;
  logic             pix_stb;
  logic [7:0]       hit_pct;

  // Captured pads with one entry per pixel strobe
  rgb_t             cap_rgb [CAP_N];
  logic             cap_hs  [CAP_N];
  logic             cap_vs  [CAP_N];
  int               cap_cyc [CAP_N];
  int               cap_n;
  logic             stb_d;
  int               cyc;
  logic [ADR_W-1:0] fml_q [$];
  rgb_t             pal_model [16];
  integer           seed;
  logic [31:0]      rnd;
  logic [15:0]      offs;
  int               test_errs;
  int               tests_passed;
  int               tests_failed;

  vga_lcd_top dut_i (
    .clk (clk), .rst (rst), .cfg_i (cfg), .start_addr_i (start_addr),
    .fml_adr_o (fml_adr), .fml_stb_o (fml_stb), .fml_ack_i (fml_ack),
    .fml_dat_i (fml_dat), .dcb_stb_o (dcb_stb), .dcb_adr_o (dcb_adr),
    .dcb_dat_i (dcb_dat), .dcb_hit_i (dcb_hit), .pal_we_i (pal_we),
    .pal_addr_i (pal_addr), .pal_dat_i (pal_dat), .rgb_o (rgb),
    .hsync_o (hsync), .vsync_o (vsync), .pix_stb_o (pix_stb)
  );

  vga_lcd_mem #(.WORDS (MEM_WORDS), .SEED (32'hd3195dca)) mem_i (
    .clk (clk), .rst (rst), .hit_pct_i (hit_pct),
    .fml_adr_i (fml_adr), .fml_stb_i (fml_stb), .fml_ack_o (fml_ack),
    .fml_dat_o (fml_dat), .dcb_stb_i (dcb_stb), .dcb_adr_i (dcb_adr),
    .dcb_dat_o (dcb_dat), .dcb_hit_o (dcb_hit)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  // Pads are valid in the cycle after a strobe
  always @(negedge clk) begin
    if (rst) begin
      stb_d = 1'b0;
    end else begin
      if (stb_d && cap_n < CAP_N) begin
        cap_rgb[cap_n] = rgb;
        cap_hs[cap_n]  = hsync;
        cap_vs[cap_n]  = vsync;
        cap_cyc[cap_n] = cyc;
        cap_n++;
      end
      if (fml_stb && fml_ack) begin
        fml_q.push_back(fml_adr);
      end
      stb_d = pix_stb;
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the pixel stream did not complete in the expected time");
    $display("=== FAIL ===");
    $finish;
  end

  // Raster order starts at the top of vertical sync
  function automatic int raster_h(int i);
    return i % H_TOT;
  endfunction

  function automatic int raster_v(int i);
    return (V_SS + (i % FRAME_PIX) / H_TOT) % V_TOT;
  endfunction

  function automatic rgb_t expected_color(int i, int start_word);
    int          h;
    int          v;
    logic [15:0] w;
    h = raster_h(i);
    v = raster_v(i);
    if (h >= H_VIS || v >= V_VIS) begin
      return '0;
    end
    // Four pixels per word, low nibble first
    w = mem_i.mem[(start_word + v * (H_VIS / 4) + h / 4) % MEM_WORDS];
    return pal_model[w[(h % 4) * 4 +: 4]];
  endfunction

  task automatic load_palette();
    for (int k = 0; k < 16; k++) begin
      @(posedge clk);
      #1;
      rnd          = $random(seed);
      pal_we       = 1'b1;
      pal_addr     = k[3:0];
      pal_dat      = rnd[11:0];
      pal_model[k] = rnd[11:0];
    end
    @(posedge clk);
    #1;
    pal_we = 1'b0;
  endtask

  // Reset, then collect two frames of strobed pixels
  task automatic run_frames(input logic [15:0] start_word, input logic [7:0] pct);
    @(posedge clk);
    #1;
    rst        = 1'b1;
    start_addr = start_word;
    hit_pct    = pct;
    repeat (4) @(posedge clk);
    #1;
    fml_q.delete();
    cap_n = 0;
    rst   = 1'b0;
    while (cap_n < CAP_N) begin
      @(posedge clk);
    end
  endtask

  // Region 0 all pixels, 1 visible only, 2 blanking only
  task automatic check_colors(input string name, input int start_word, input int region);
    int   h;
    int   v;
    logic vis;
    rgb_t exp;
    for (int i = 0; i < CAP_N; i++) begin
      h   = raster_h(i);
      v   = raster_v(i);
      vis = (h < H_VIS) && (v < V_VIS);
      exp = expected_color(i, start_word);
      if (region == 0 || (region == 1 && vis) || (region == 2 && !vis)) begin
        assert (cap_rgb[i] == exp) else begin
          $display("Mismatch %s pixel %0d (h %0d v %0d): expected %h, actual %h",
                   name, i, h, v, exp, cap_rgb[i]);
          test_errs++;
        end
      end
    end
  endtask

  task automatic check_sync(input string name);
    int   h;
    int   v;
    logic hs_exp;
    logic vs_exp;
    for (int i = 0; i < CAP_N; i++) begin
      h      = raster_h(i);
      v      = raster_v(i);
      hs_exp = !(h >= H_SS && h < H_SE);
      vs_exp = !(v >= V_SS && v < V_SE);
      assert ({cap_hs[i], cap_vs[i]} == {hs_exp, vs_exp}) else begin
        $display("Mismatch %s sync at pixel %0d: expected %b%b, actual %b%b",
                 name, i, hs_exp, vs_exp, cap_hs[i], cap_vs[i]);
        test_errs++;
      end
    end
  endtask

  // Bursts of one frame walk the words in order
  task automatic check_fml_addr(input string name, input int start_word);
    logic [ADR_W-1:0] exp;
    assert (fml_q.size() >= 2 * BURSTS) else begin
      $display("Test %s saw only %0d FML bursts, %0d expected",
               name, fml_q.size(), 2 * BURSTS);
      test_errs++;
    end
    for (int j = 0; j < fml_q.size(); j++) begin
      exp = ADR_W'((start_word + BURST * (j % BURSTS)) * 2);
      assert (fml_q[j] == exp) else begin
        $display("Mismatch %s FML burst %0d: expected %h, actual %h", name, j, exp, fml_q[j]);
        test_errs++;
      end
    end
  endtask

  // With every cache lookup a hit no burst may reach FML
  task automatic check_cache_only(input string name);
    assert (fml_q.size() == 0) else begin
      $display("Test %s still fetched %0d bursts over FML", name, fml_q.size());
      test_errs++;
    end
  endtask

  task automatic check_repeat(input string name);
    int first_vis;
    int gap;
    first_vis = -1;
    for (int i = 0; i < FRAME_PIX; i++) begin
      assert ({cap_rgb[i + FRAME_PIX], cap_hs[i + FRAME_PIX], cap_vs[i + FRAME_PIX]}
              == {cap_rgb[i], cap_hs[i], cap_vs[i]}) else begin
        $display("Mismatch %s second frame pixel %0d: expected %h, actual %h", name, i,
                 {cap_rgb[i], cap_hs[i], cap_vs[i]},
                 {cap_rgb[i + FRAME_PIX], cap_hs[i + FRAME_PIX], cap_vs[i + FRAME_PIX]});
        test_errs++;
      end
      if (first_vis < 0 && raster_h(i) < H_VIS && raster_v(i) < V_VIS) begin
        first_vis = i;
      end
    end
    // Strobe cadence once the picture has started
    for (int i = first_vis + 1; i < CAP_N; i++) begin
      gap = cap_cyc[i] - cap_cyc[i - 1];
      assert (gap <= 4) else begin
        $display("Test %s: pixel strobe paused for %0d cycles before pixel %0d", name, gap, i);
        test_errs++;
      end
    end
  endtask

  task automatic finish_test(input int num, input string name);
    if (test_errs == 0) begin
      tests_passed++;
      $display("Test %0d %s: ok", num, name);
    end else begin
      tests_failed++;
      $display("Test %0d %s: %0d errors", num, name, test_errs);
    end
    test_errs = 0;
  endtask

  initial begin
    seed             = 32'hd3195dca;
    clk              = 1'b0;
    rst              = 1'b1;
    cfg.h_total      = 10'(H_TOT);
    cfg.h_visible    = 10'(H_VIS);
    cfg.h_sync_start = 10'(H_SS);
    cfg.h_sync_end   = 10'(H_SE);
    cfg.v_total      = 10'(V_TOT);
    cfg.v_visible    = 10'(V_VIS);
    cfg.v_sync_start = 10'(V_SS);
    cfg.v_sync_end   = 10'(V_SE);
    start_addr       = '0;
    pal_we           = 1'b0;
    pal_addr         = '0;
    pal_dat          = '0;
    hit_pct          = 8'd50;
    cap_n            = CAP_N;
    test_errs        = 0;
    tests_passed     = 0;
    tests_failed     = 0;
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;

    load_palette();
    run_frames(16'd0, 8'd50);
    check_colors("palette", 0, 1);
    finish_test(1, "palette");

    run_frames(16'd0, 8'd50);
    check_colors("blanking", 0, 2);
    finish_test(2, "blanking");

    run_frames(16'd0, 8'd50);
    check_sync("sync");
    finish_test(3, "sync");

    // All bursts through FML so every address is visible
    rnd  = $random(seed);
    offs = 16'd1 + {5'd0, rnd[10:0]};
    run_frames(offs, 8'd0);
    check_colors("offset", offs, 0);
    check_fml_addr("offset", offs);
    finish_test(4, "offset");

    run_frames(16'd0, 8'd0);
    check_colors("source_miss", 0, 0);
    check_fml_addr("source_miss", 0);
    run_frames(16'd0, 8'd100);
    check_colors("source_hit", 0, 0);
    check_cache_only("source_hit");
    run_frames(16'd0, 8'd50);
    check_colors("source_mixed", 0, 0);
    finish_test(5, "source");

    run_frames(16'd0, 8'd50);
    check_repeat("repeat");
    finish_test(6, "repeat");

    $display("%0d tests run, %0d passed, %0d failed", NUM_TESTS, tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

//--- vga_lcd_top.f
+incdir+src
src/vga_lcd_pkg.sv
src/vga_crtc.sv
src/vga_sequencer.sv
src/vga_fifo.sv
src/vga_fetch_ctrl.sv
src/vga_pal_out.sv
src/vga_lcd_top.sv
sim/vga_lcd_mem.sv
sim/vga_lcd_tb.sv

//--- Bender.yml
package:
  name: vga_lcd

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/vga_lcd_pkg.sv
      - src/vga_crtc.sv
      - src/vga_sequencer.sv
      - src/vga_fifo.sv
      - src/vga_fetch_ctrl.sv
      - src/vga_pal_out.sv
      - src/vga_lcd_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - sim/vga_lcd_mem.sv
      - sim/vga_lcd_tb.sv
